/* Bender.yml */
package:
  name: vertical_filter

sources:
  - vf_pkg.sv
  - line_buffer.sv
  - frame_row_sequencer.sv
  - row_window_buffer.sv
  - vertical_sum_filter.sv
  - vertical_filter_top.sv
  - target: simulation
    files:
      - vertical_filter_checker.sv
      - vertical_filter_sva.sv
      - tb_vertical_filter.sv

/* flist.f */
vf_pkg.sv
line_buffer.sv
frame_row_sequencer.sv
row_window_buffer.sv
vertical_sum_filter.sv
vertical_filter_top.sv
vertical_filter_checker.sv
vertical_filter_sva.sv
tb_vertical_filter.sv

/* frame_row_sequencer.sv */
`timescale 1ns/1ps

module frame_row_sequencer (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frame_start_i,
  input  vf_pkg::pixel_t pixel_i,
  output vf_pkg::pixel_t pixel_o,
  output logic           sof_o,
  output logic           row_done_o
);

  vf_pkg::pixel_t pixel_q;
  vf_pkg::col_t   col_q;
  logic           sof_q;
  logic           running_q;

  always_ff @(posedge clk) begin
    pixel_q <= pixel_i;
  end

  // col_q tracks the column of pixel_q.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sof_q     <= 1'b0;
      col_q     <= '0;
      running_q <= 1'b0;
    end else begin
      sof_q <= frame_start_i;
      if (frame_start_i) begin
        col_q     <= '0;
        running_q <= 1'b1;
      end else if (col_q == vf_pkg::LAST_COL) begin
        col_q <= '0;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  assign pixel_o = pixel_q;
  assign sof_o   = sof_q;

  // no row boundaries until the first frame start.
  assign row_done_o = running_q && (col_q == vf_pkg::LAST_COL);

endmodule

/* line_buffer.sv */
`timescale 1ns/1ps

module line_buffer #(
  parameter type payload_t = vf_pkg::pixel_t,
  parameter int  DEPTH     = vf_pkg::ROW_LEN
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t shift_q [DEPTH];

  // one entry per cycle of delay.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        shift_q[i] <= '0;
      end
    end else begin
      shift_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        shift_q[i] <= shift_q[i-1];
      end
    end
  end

  // oldest entry leaves.
  assign data_o = shift_q[DEPTH-1];

endmodule

/* row_window_buffer.sv */
`timescale 1ns/1ps

module row_window_buffer (
  input  logic           clk,
  input  logic           rst_n,
  input  vf_pkg::pixel_t pixel_i,
  input  logic           row_done_i,
  output vf_pkg::pixel_t tap0_o,
  output vf_pkg::pixel_t tap1_o,
  output vf_pkg::pixel_t tap2_o,
  output vf_pkg::pixel_t tap3_o,
  output vf_pkg::pixel_t tap4_o,
  output vf_pkg::pixel_t tap5_o,
  output vf_pkg::pixel_t tap6_o,
  output vf_pkg::pixel_t tap7_o,
  output vf_pkg::pixel_t tap8_o,
  output vf_pkg::pixel_t tap9_o,
  output vf_pkg::pixel_t tap10_o,
  output vf_pkg::pixel_t tap11_o,
  output vf_pkg::pixel_t tap12_o,
  output logic           done_r4_o,
  output logic           done_r8_o,
  output logic           done_r12_o
);

  // entry k is k rows older than the input.
  vf_pkg::pixel_t pix_chain  [vf_pkg::NUM_TAPS];
  logic           done_chain [vf_pkg::NUM_TAPS];

  assign pix_chain[0]  = pixel_i;
  assign done_chain[0] = row_done_i;

  for (genvar i = 0; i < vf_pkg::NUM_TAPS - 1; i++) begin : gen_rows
    line_buffer #(
      .payload_t (vf_pkg::pixel_t),
      .DEPTH     (vf_pkg::ROW_LEN)
    ) i_pixel_lb (
      .clk    (clk),
      .rst_n  (rst_n),
      .data_i (pix_chain[i]),
      .data_o (pix_chain[i+1])
    );

    // row marks travel alongside the pixels.
    line_buffer #(
      .payload_t (logic),
      .DEPTH     (vf_pkg::ROW_LEN)
    ) i_done_lb (
      .clk    (clk),
      .rst_n  (rst_n),
      .data_i (done_chain[i]),
      .data_o (done_chain[i+1])
    );
  end

  assign tap0_o  = pix_chain[0];
  assign tap1_o  = pix_chain[1];
  assign tap2_o  = pix_chain[2];
  assign tap3_o  = pix_chain[3];
  assign tap4_o  = pix_chain[4];
  assign tap5_o  = pix_chain[5];
  assign tap6_o  = pix_chain[6];
  assign tap7_o  = pix_chain[7];
  assign tap8_o  = pix_chain[8];
  assign tap9_o  = pix_chain[9];
  assign tap10_o = pix_chain[10];
  assign tap11_o = pix_chain[11];
  assign tap12_o = pix_chain[12];

  assign done_r4_o  = done_chain[4];
  assign done_r8_o  = done_chain[8];
  assign done_r12_o = done_chain[12];

endmodule

/* tb_vertical_filter.sv */
`timescale 1ns/1ps

module tb_vertical_filter;

  logic           clk;
  logic           rst_n;
  logic           frame_start_i;
  vf_pkg::pixel_t pixel_i;
  vf_pkg::sum_t   sum5_o;
  vf_pkg::sum_t   sum9_o;
  vf_pkg::sum_t   sum13_o;
  logic           valid5_o;
  logic           valid9_o;
  logic           valid13_o;
  int             checker_errors;
  int             checker_checks;
  int             wait_errors = 0;
  logic [31:0]    lcg_state = 32'h705780d0;
  logic           saturate = 1'b0;

  vertical_filter_top i_vertical_filter_top (.*);

  vertical_filter_checker i_vertical_filter_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start_i),
    .pixel_i       (pixel_i),
    .sum5_i        (sum5_o),
    .sum9_i        (sum9_o),
    .sum13_i       (sum13_o),
    .valid5_i      (valid5_o),
    .valid9_i      (valid9_o),
    .valid13_i     (valid13_o),
    .errors_o      (checker_errors),
    .checks_o      (checker_checks)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_errors();
    return checker_errors + wait_errors + i_vertical_filter_top.i_vertical_filter_sva.failures;
  endfunction

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // one pixel per clock with no pauses.
  always @(posedge clk) begin
    if (!rst_n) begin
      pixel_i <= '0;
    end else if (saturate) begin
      pixel_i <= 8'hff;
    end else begin
      lcg_state = lcg_next(lcg_state);
      pixel_i <= lcg_state[23:16];
    end
  end

  task automatic start_frame();
    @(posedge clk);
    frame_start_i <= 1'b1;
    @(posedge clk);
    frame_start_i <= 1'b0;
  endtask

  // size selects valid5_o, valid9_o or valid13_o.
  task automatic wait_valid(input int size, input int limit);
    int   cycles;
    logic level;
    cycles = 0;
    level  = 1'b0;
    while (level !== 1'b1 && cycles < limit) begin
      @(posedge clk);
      cycles++;
      level = (size == 5) ? valid5_o : (size == 9) ? valid9_o : valid13_o;
    end
    if (level !== 1'b1) begin
      wait_errors++;
      $display("Timeout at %0t: valid%0d_o did not rise within %0d cycles", $time, size, limit);
    end
  endtask

  task automatic wait_max_sum(input int limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(posedge clk);
      cycles++;
      seen = valid13_o && sum13_o == vf_pkg::sum_t'(vf_pkg::NUM_TAPS * 255);
    end
    if (!seen) begin
      wait_errors++;
      $display("Timeout at %0t: sum13_o never reached the all-255 maximum", $time);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int found;
    @(negedge clk);
    found = total_errors() - errors_before;
    if (found == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d errors", name, found);
    end
  endtask

  initial begin
    int mark;
    rst_n         = 1'b0;
    frame_start_i = 1'b0;
    pixel_i       = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    mark = total_errors();
    repeat (3 * vf_pkg::ROW_LEN) @(posedge clk);
    report_test("idle before frame start", mark);

    mark = total_errors();
    start_frame();
    wait_valid(5, 8 * vf_pkg::ROW_LEN);
    repeat (2 * vf_pkg::ROW_LEN) @(posedge clk);
    report_test("5-row window", mark);

    mark = total_errors();
    wait_valid(9, 6 * vf_pkg::ROW_LEN);
    repeat (2 * vf_pkg::ROW_LEN) @(posedge clk);
    report_test("9-row window", mark);

    // random rows around a saturated band.
    mark = total_errors();
    wait_valid(13, 6 * vf_pkg::ROW_LEN);
    repeat (3 * vf_pkg::ROW_LEN) @(posedge clk);
    saturate <= 1'b1;
    repeat (15 * vf_pkg::ROW_LEN) @(posedge clk);
    saturate <= 1'b0;
    wait_max_sum(4 * vf_pkg::ROW_LEN);
    repeat (2 * vf_pkg::ROW_LEN) @(posedge clk);
    report_test("13-row window", mark);

    // restart off the row boundary.
    mark = total_errors();
    repeat (5) @(posedge clk);
    start_frame();
    wait_valid(5, 8 * vf_pkg::ROW_LEN);
    wait_valid(9, 6 * vf_pkg::ROW_LEN);
    wait_valid(13, 6 * vf_pkg::ROW_LEN);
    repeat (vf_pkg::ROW_LEN) @(posedge clk);
    report_test("frame restart", mark);

    $display("%0d checks, %0d errors", checker_checks, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vertical_filter_checker.sv */
`timescale 1ns/1ps

module vertical_filter_checker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frame_start_i,
  input  vf_pkg::pixel_t pixel_i,
  input  vf_pkg::sum_t   sum5_i,
  input  vf_pkg::sum_t   sum9_i,
  input  vf_pkg::sum_t   sum13_i,
  input  logic           valid5_i,
  input  logic           valid9_i,
  input  logic           valid13_i,
  output int             errors_o,
  output int             checks_o
);

  // one entry per clock edge since time zero.
  vf_pkg::pixel_t pix_hist [$];
  bit             start_hist [$];
  bit             row_end_hist [$];
  bit             exp_valid [3];
  logic           dut_valid [3];
  vf_pkg::sum_t   dut_sum [3];
  int             edge_n = 0;
  int             last_start = -1;
  bit             seen_reset = 1'b0;
  int             exp_sum;
  int             errors = 0;
  int             checks = 0;

  assign errors_o = errors;
  assign checks_o = checks;

  function automatic int pixel_at(int idx);
    if (idx < 0 || idx >= pix_hist.size()) begin
      return 0;
    end
    return int'(pix_hist[idx]);
  endfunction

  function automatic bit row_end_at(int idx);
    if (idx < 0 || idx >= row_end_hist.size()) begin
      return 1'b0;
    end
    return row_end_hist[idx];
  endfunction

  // sum of 2*half+1 rows around the centre tap as shown at edge n.
  function automatic int ref_sum(int n, int half);
    int acc;
    acc = 0;
    for (int k = vf_pkg::CENTRE_TAP - half; k <= vf_pkg::CENTRE_TAP + half; k++) begin
      acc += pixel_at(n - 2 - k * vf_pkg::ROW_LEN);
    end
    return acc;
  endfunction

  always @(posedge clk) begin
    dut_valid[0] = valid5_i;
    dut_valid[1] = valid9_i;
    dut_valid[2] = valid13_i;
    dut_sum[0]   = sum5_i;
    dut_sum[1]   = sum9_i;
    dut_sum[2]   = sum13_i;
    pix_hist.push_back(pixel_i);
    if (seen_reset) begin
      for (int i = 0; i < 3; i++) begin
        checks++;
        if (dut_valid[i] !== exp_valid[i]) begin
          errors++;
          $display("Mismatch at %0t: valid%0d_o is %b, expected %b",
                   $time, 4 * i + 5, dut_valid[i], exp_valid[i]);
        end
        if (exp_valid[i]) begin
          exp_sum = ref_sum(edge_n, 2 * i + 2);
          checks++;
          if (dut_sum[i] !== vf_pkg::sum_t'(exp_sum)) begin
            errors++;
            $display("Mismatch at %0t: sum%0d_o is %0d, expected %0d",
                     $time, 4 * i + 5, dut_sum[i], exp_sum);
          end
        end
      end
    end
    // rows restart at every frame start.
    if (!rst_n) begin
      last_start = -1;
      seen_reset = 1'b1;
    end else if (frame_start_i) begin
      last_start = edge_n;
    end
    start_hist.push_back(rst_n && frame_start_i);
    row_end_hist.push_back(last_start >= 0 &&
                           (edge_n - last_start) % vf_pkg::ROW_LEN == vf_pkg::ROW_LEN - 1);
    // levels as they are registered at this edge.
    for (int i = 0; i < 3; i++) begin
      if (!rst_n) begin
        exp_valid[i] = 1'b0;
      end else if (edge_n > 0 && start_hist[edge_n - 1]) begin
        exp_valid[i] = 1'b0;
      end else if (row_end_at(edge_n - 1 - 4 * (i + 1) * vf_pkg::ROW_LEN)) begin
        exp_valid[i] = 1'b1;
      end
    end
    edge_n++;
  end

endmodule

/* vertical_filter_sva.sv */
`timescale 1ns/1ps

module vertical_filter_sva (
  input logic clk,
  input logic rst_n,
  input logic sof_i,
  input logic row_done_i,
  input logic valid5_i,
  input logic valid9_i,
  input logic valid13_i
);

  int failures = 0;

  // a row never ends on the first pixel of a frame.
  sof_apart_from_row_done: assert property (
    @(posedge clk) disable iff (!rst_n) !(sof_i && row_done_i)
  ) else begin
    failures++;
    $error("sof and row_done are high in the same cycle");
  end

  row_done_period: assert property (
    @(posedge clk) disable iff (!rst_n || sof_i)
    row_done_i |=> !row_done_i [*vf_pkg::ROW_LEN-1] ##1 row_done_i
  ) else begin
    failures++;
    $error("row_done did not repeat after a full row");
  end

  valids_low_after_reset: assert property (
    @(posedge clk) !rst_n |=> !valid5_i && !valid9_i && !valid13_i
  ) else begin
    failures++;
    $error("a valid level is high right after reset");
  end

  valids_cleared_by_sof: assert property (
    @(posedge clk) disable iff (!rst_n) sof_i |=> !valid5_i && !valid9_i && !valid13_i
  ) else begin
    failures++;
    $error("a valid level survived a frame start");
  end

endmodule

bind vertical_filter_top vertical_filter_sva i_vertical_filter_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .sof_i      (sof_q),
  .row_done_i (row_done),
  .valid5_i   (valid5_o),
  .valid9_i   (valid9_o),
  .valid13_i  (valid13_o)
);

/* vertical_filter_top.sv */
`timescale 1ns/1ps

module vertical_filter_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frame_start_i,
  input  vf_pkg::pixel_t pixel_i,
  output vf_pkg::sum_t   sum5_o,
  output vf_pkg::sum_t   sum9_o,
  output vf_pkg::sum_t   sum13_o,
  output logic           valid5_o,
  output logic           valid9_o,
  output logic           valid13_o
);

  vf_pkg::pixel_t pixel_q;
  logic           sof_q;
  logic           row_done;
  vf_pkg::pixel_t tap0;
  vf_pkg::pixel_t tap1;
  vf_pkg::pixel_t tap2;
  vf_pkg::pixel_t tap3;
  vf_pkg::pixel_t tap4;
  vf_pkg::pixel_t tap5;
  vf_pkg::pixel_t tap6;
  vf_pkg::pixel_t tap7;
  vf_pkg::pixel_t tap8;
  vf_pkg::pixel_t tap9;
  vf_pkg::pixel_t tap10;
  vf_pkg::pixel_t tap11;
  vf_pkg::pixel_t tap12;
  logic           done_r4;
  logic           done_r8;
  logic           done_r12;

  frame_row_sequencer i_frame_row_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start_i),
    .pixel_i       (pixel_i),
    .pixel_o       (pixel_q),
    .sof_o         (sof_q),
    .row_done_o    (row_done)
  );

  row_window_buffer i_row_window_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pixel_i    (pixel_q),
    .row_done_i (row_done),
    .tap0_o     (tap0),
    .tap1_o     (tap1),
    .tap2_o     (tap2),
    .tap3_o     (tap3),
    .tap4_o     (tap4),
    .tap5_o     (tap5),
    .tap6_o     (tap6),
    .tap7_o     (tap7),
    .tap8_o     (tap8),
    .tap9_o     (tap9),
    .tap10_o    (tap10),
    .tap11_o    (tap11),
    .tap12_o    (tap12),
    .done_r4_o  (done_r4),
    .done_r8_o  (done_r8),
    .done_r12_o (done_r12)
  );

  // sums appear two cycles after the pixel enters.
  vertical_sum_filter i_vertical_sum_filter (
    .clk        (clk),
    .rst_n      (rst_n),
    .sof_i      (sof_q),
    .tap0_i     (tap0),
    .tap1_i     (tap1),
    .tap2_i     (tap2),
    .tap3_i     (tap3),
    .tap4_i     (tap4),
    .tap5_i     (tap5),
    .tap6_i     (tap6),
    .tap7_i     (tap7),
    .tap8_i     (tap8),
    .tap9_i     (tap9),
    .tap10_i    (tap10),
    .tap11_i    (tap11),
    .tap12_i    (tap12),
    .done_r4_i  (done_r4),
    .done_r8_i  (done_r8),
    .done_r12_i (done_r12),
    .sum5_o     (sum5_o),
    .sum9_o     (sum9_o),
    .sum13_o    (sum13_o),
    .valid5_o   (valid5_o),
    .valid9_o   (valid9_o),
    .valid13_o  (valid13_o)
  );

endmodule

/* vertical_sum_filter.sv */
`timescale 1ns/1ps

module vertical_sum_filter (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           sof_i,
  input  vf_pkg::pixel_t tap0_i,
  input  vf_pkg::pixel_t tap1_i,
  input  vf_pkg::pixel_t tap2_i,
  input  vf_pkg::pixel_t tap3_i,
  input  vf_pkg::pixel_t tap4_i,
  input  vf_pkg::pixel_t tap5_i,
  input  vf_pkg::pixel_t tap6_i,
  input  vf_pkg::pixel_t tap7_i,
  input  vf_pkg::pixel_t tap8_i,
  input  vf_pkg::pixel_t tap9_i,
  input  vf_pkg::pixel_t tap10_i,
  input  vf_pkg::pixel_t tap11_i,
  input  vf_pkg::pixel_t tap12_i,
  input  logic           done_r4_i,
  input  logic           done_r8_i,
  input  logic           done_r12_i,
  output vf_pkg::sum_t   sum5_o,
  output vf_pkg::sum_t   sum9_o,
  output vf_pkg::sum_t   sum13_o,
  output logic           valid5_o,
  output logic           valid9_o,
  output logic           valid13_o
);

  vf_pkg::pixel_t taps [vf_pkg::NUM_TAPS];
  vf_pkg::sum_t   sum5_d;
  vf_pkg::sum_t   sum9_d;
  vf_pkg::sum_t   sum13_d;
  vf_pkg::sum_t   sum5_q;
  vf_pkg::sum_t   sum9_q;
  vf_pkg::sum_t   sum13_q;
  logic           valid5_q;
  logic           valid9_q;
  logic           valid13_q;

  assign taps[0]  = tap0_i;
  assign taps[1]  = tap1_i;
  assign taps[2]  = tap2_i;
  assign taps[3]  = tap3_i;
  assign taps[4]  = tap4_i;
  assign taps[5]  = tap5_i;
  assign taps[6]  = tap6_i;
  assign taps[7]  = tap7_i;
  assign taps[8]  = tap8_i;
  assign taps[9]  = tap9_i;
  assign taps[10] = tap10_i;
  assign taps[11] = tap11_i;
  assign taps[12] = tap12_i;

  // windows of half width 2, 4 and 6 around the centre tap.
  always_comb begin
    sum5_d  = '0;
    sum9_d  = '0;
    sum13_d = '0;
    for (int k = 0; k < vf_pkg::NUM_TAPS; k++) begin
      if (k >= vf_pkg::CENTRE_TAP - 2 && k <= vf_pkg::CENTRE_TAP + 2) begin
        sum5_d = sum5_d + vf_pkg::sum_t'(taps[k]);
      end
      if (k >= vf_pkg::CENTRE_TAP - 4 && k <= vf_pkg::CENTRE_TAP + 4) begin
        sum9_d = sum9_d + vf_pkg::sum_t'(taps[k]);
      end
      if (k >= vf_pkg::CENTRE_TAP - 6 && k <= vf_pkg::CENTRE_TAP + 6) begin
        sum13_d = sum13_d + vf_pkg::sum_t'(taps[k]);
      end
    end
  end

  always_ff @(posedge clk) begin
    sum5_q  <= sum5_d;
    sum9_q  <= sum9_d;
    sum13_q <= sum13_d;
  end

  // a new frame clears every window.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid5_q  <= 1'b0;
      valid9_q  <= 1'b0;
      valid13_q <= 1'b0;
    end else if (sof_i) begin
      valid5_q  <= 1'b0;
      valid9_q  <= 1'b0;
      valid13_q <= 1'b0;
    end else begin
      if (done_r4_i) begin
        valid5_q <= 1'b1;
      end
      if (done_r8_i) begin
        valid9_q <= 1'b1;
      end
      if (done_r12_i) begin
        valid13_q <= 1'b1;
      end
    end
  end

  assign sum5_o    = sum5_q;
  assign sum9_o    = sum9_q;
  assign sum13_o   = sum13_q;
  assign valid5_o  = valid5_q;
  assign valid9_o  = valid9_q;
  assign valid13_o = valid13_q;

endmodule

/* vf_pkg.sv */
package vf_pkg;

  // pixels per image row.
  localparam int ROW_LEN = 17;

  // twelve row delays plus the live row.
  localparam int NUM_TAPS = 13;

  // middle tap of the window.
  localparam int CENTRE_TAP = (NUM_TAPS - 1) / 2;

  // unsigned 8-bit pixel.
  typedef logic [7:0] pixel_t;

  // holds 13 * 255.
  typedef logic [11:0] sum_t;

  // column index within a row.
  typedef logic [4:0] col_t;

  // last column of a row.
  localparam col_t LAST_COL = col_t'(ROW_LEN - 1);

endpackage
